// File: filelist.f
source/bus_pkg.sv
source/bus_router.sv
source/sram_controller.sv
source/serial_controller.sv
source/soc_bus_top.sv
test/soc_bus_checker.sv
test/soc_bus_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the bus testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module soc_bus_tb -o soc_bus_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/soc_bus_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1

// File: source/bus_pkg.sv
package bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [3:0]  mask_t;     // 1 = lane written

    // address map, fixed by the board
    localparam addr_t EXT_BASE       = 32'h8000_0000;
    localparam addr_t BASE_BASE      = 32'h8040_0000;
    localparam addr_t REGION_SIZE    = 32'h0040_0000; // 4 MiB each
    localparam addr_t UART_DATA_ADDR = 32'hBFD0_03F8;
    localparam addr_t UART_STAT_ADDR = 32'hBFD0_03FC;

    localparam int SRAM_ADDR_W    = 20;  // word address at the ram pins
    localparam int ACCESS_LATENCY = 2;   // request cycle to resp valid

    // one-cycle strobe request, read and write never both set
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t addr;
        word_t wdata;
        mask_t mask;
    } mem_req_t;

    typedef struct packed {
        logic  valid;   // single pulse
        word_t rdata;   // only meaningful for reads
    } mem_resp_t;

    typedef enum logic [2:0] {
        TGT_EXT,
        TGT_BASE,
        TGT_UART_DATA,
        TGT_UART_STAT,
        TGT_NONE
    } target_e;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_SECOND,    // held data request goes out
        ARB_WAIT       // instruction result returning
    } arb_state_e;

endpackage

// File: source/bus_router.sv
`timescale 1ns/1ps

module bus_router (
    input  logic               clk_50M,
    input  logic               rst_i,
    input  bus_pkg::mem_req_t  inst_req_i,
    input  bus_pkg::mem_req_t  data_req_i,
    output bus_pkg::mem_resp_t inst_resp_o,
    output bus_pkg::mem_resp_t data_resp_o,
    output logic               stall_o,
    output bus_pkg::mem_req_t  ext_req_o,
    output bus_pkg::mem_req_t  base_req_o,
    output bus_pkg::mem_req_t  uart_req_o,
    input  bus_pkg::mem_resp_t ext_resp_i,
    input  bus_pkg::mem_resp_t base_resp_i,
    input  bus_pkg::mem_resp_t uart_resp_i,
    input  logic [1:0]         uart_status_i
);

    bus_pkg::arb_state_e state_q;
    bus_pkg::target_e    inst_tgt, data_tgt, b_tgt;
    bus_pkg::target_e    hold_tgt_q;
    bus_pkg::mem_req_t   inst_rd, b_req, hold_q;
    logic                inst_act, data_act, b_act, conflict;

    // valid pipelines, target travels next to each stage
    logic [bus_pkg::ACCESS_LATENCY-1:0] inst_v_q, data_v_q;
    bus_pkg::target_e inst_tgt_q [bus_pkg::ACCESS_LATENCY];
    bus_pkg::target_e data_tgt_q [bus_pkg::ACCESS_LATENCY];

    function automatic bus_pkg::target_e decode(input bus_pkg::addr_t a);
        if (a >= bus_pkg::EXT_BASE && a < bus_pkg::EXT_BASE + bus_pkg::REGION_SIZE)
            return bus_pkg::TGT_EXT;
        if (a >= bus_pkg::BASE_BASE && a < bus_pkg::BASE_BASE + bus_pkg::REGION_SIZE)
            return bus_pkg::TGT_BASE;
        if (a == bus_pkg::UART_DATA_ADDR)
            return bus_pkg::TGT_UART_DATA;
        if (a == bus_pkg::UART_STAT_ADDR)
            return bus_pkg::TGT_UART_STAT;
        return bus_pkg::TGT_NONE;
    endfunction

    // virtual byte address -> physical word address, bits 21:2
    function automatic bus_pkg::mem_req_t to_ram(input bus_pkg::mem_req_t r);
        bus_pkg::mem_req_t p;
        p      = r;
        p.addr = bus_pkg::addr_t'(r.addr[bus_pkg::SRAM_ADDR_W+1:2]);
        return p;
    endfunction

    // instruction side has priority on a device
    function automatic bus_pkg::mem_req_t pick(input bus_pkg::target_e dev,
                                               input logic a_act,
                                               input bus_pkg::target_e a_tgt,
                                               input bus_pkg::mem_req_t a_req,
                                               input logic b_act_in,
                                               input bus_pkg::target_e b_tgt_in,
                                               input bus_pkg::mem_req_t b_req_in);
        if (a_act && a_tgt == dev)
            return a_req;
        if (b_act_in && b_tgt_in == dev)
            return b_req_in;
        return '0;
    endfunction

    function automatic bus_pkg::mem_resp_t steer(input bus_pkg::target_e tgt,
                                                 input logic pend,
                                                 input bus_pkg::mem_resp_t ext,
                                                 input bus_pkg::mem_resp_t base,
                                                 input bus_pkg::mem_resp_t uart,
                                                 input logic [1:0] status);
        bus_pkg::mem_resp_t r;
        r.valid = pend;     // router-answered targets: pipeline alone
        r.rdata = '0;       // unmapped reads as zero
        case (tgt)
            bus_pkg::TGT_EXT: r = '{valid: pend & ext.valid, rdata: ext.rdata};
            bus_pkg::TGT_BASE: r = '{valid: pend & base.valid, rdata: base.rdata};
            bus_pkg::TGT_UART_DATA: r = '{valid: pend & uart.valid, rdata: uart.rdata};
            bus_pkg::TGT_UART_STAT: r.rdata = {30'b0, status};
            default: ;
        endcase
        return r;
    endfunction

    assign inst_tgt = decode(inst_req_i.addr);
    assign data_tgt = decode(data_req_i.addr);

    always_comb begin
        inst_rd      = '0;             // fetch is read only, full word
        inst_rd.read = inst_req_i.read;
        inst_rd.addr = inst_req_i.addr;
        inst_act = (state_q == bus_pkg::ARB_IDLE) && inst_req_i.read;
        data_act = (state_q == bus_pkg::ARB_IDLE) && (data_req_i.read || data_req_i.write);
        conflict = inst_act && data_act && (inst_tgt == data_tgt) &&
                   (inst_tgt inside {bus_pkg::TGT_EXT, bus_pkg::TGT_BASE,
                                     bus_pkg::TGT_UART_DATA});
        if (state_q == bus_pkg::ARB_SECOND) begin
            b_act = 1'b1;              // replay the held data access
            b_tgt = hold_tgt_q;
            b_req = hold_q;
        end else begin
            b_act = data_act && !conflict;
            b_tgt = data_tgt;
            b_req = data_req_i;
        end
    end

    assign ext_req_o  = to_ram(pick(bus_pkg::TGT_EXT, inst_act, inst_tgt, inst_rd,
                                    b_act, b_tgt, b_req));
    assign base_req_o = to_ram(pick(bus_pkg::TGT_BASE, inst_act, inst_tgt, inst_rd,
                                    b_act, b_tgt, b_req));
    assign uart_req_o = pick(bus_pkg::TGT_UART_DATA, inst_act, inst_tgt, inst_rd,
                             b_act, b_tgt, b_req);

    always_ff @(posedge clk_50M) begin
        if (rst_i) begin
            state_q  <= bus_pkg::ARB_IDLE;
            inst_v_q <= '0;
            data_v_q <= '0;
        end else begin
            inst_v_q <= {inst_v_q[bus_pkg::ACCESS_LATENCY-2:0], inst_act};
            data_v_q <= {data_v_q[bus_pkg::ACCESS_LATENCY-2:0], b_act};
            case (state_q)
                bus_pkg::ARB_IDLE:   if (conflict) state_q <= bus_pkg::ARB_SECOND;
                bus_pkg::ARB_SECOND: state_q <= bus_pkg::ARB_WAIT;
                default:             state_q <= bus_pkg::ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_50M) begin
        if (conflict) begin          // park data side for one cycle
            hold_q     <= data_req_i;
            hold_tgt_q <= data_tgt;
        end
        inst_tgt_q[0] <= inst_tgt;
        data_tgt_q[0] <= b_tgt;
        for (int i = 1; i < bus_pkg::ACCESS_LATENCY; i++) begin
            inst_tgt_q[i] <= inst_tgt_q[i-1];
            data_tgt_q[i] <= data_tgt_q[i-1];
        end
    end

    assign stall_o = (state_q != bus_pkg::ARB_IDLE);

    assign inst_resp_o = steer(inst_tgt_q[bus_pkg::ACCESS_LATENCY-1],
                               inst_v_q[bus_pkg::ACCESS_LATENCY-1],
                               ext_resp_i, base_resp_i, uart_resp_i, uart_status_i);
    assign data_resp_o = steer(data_tgt_q[bus_pkg::ACCESS_LATENCY-1],
                               data_v_q[bus_pkg::ACCESS_LATENCY-1],
                               ext_resp_i, base_resp_i, uart_resp_i, uart_status_i);

endmodule

// File: source/serial_controller.sv
`timescale 1ns/1ps

module serial_controller (
    input  logic               clk_50M,
    input  logic               rst_i,
    input  bus_pkg::mem_req_t  req_i,
    output bus_pkg::mem_resp_t resp_o,
    output logic [1:0]         status_o,
    output logic               uart_rdn_o,
    output logic               uart_wrn_o,
    input  logic               uart_dataready_i,
    input  logic               uart_tbre_i,
    input  logic               uart_tsre_i,
    inout  wire  [7:0]         uart_data_io
);

    logic       drive_q;
    logic       valid_q;
    logic [7:0] wbyte_q;   // byte going out
    logic [7:0] rbyte_q;   // byte last read from the chip

    // rdn / wrn low for the single cycle after the request
    always_ff @(posedge clk_50M) begin
        if (rst_i) begin
            uart_rdn_o <= 1'b1;
            uart_wrn_o <= 1'b1;
            drive_q    <= 1'b0;
            valid_q    <= 1'b0;
        end else begin
            uart_rdn_o <= ~req_i.read;
            uart_wrn_o <= ~req_i.write;
            // chip latches on the wrn rising edge,
            // so data stays on the bus one cycle past it
            drive_q    <= req_i.write | ~uart_wrn_o;
            valid_q    <= ~uart_rdn_o | ~uart_wrn_o;
        end
    end

    always_ff @(posedge clk_50M) begin
        if (req_i.write)
            wbyte_q <= req_i.wdata[7:0];    // upper bytes ignored
        if (!uart_rdn_o)
            rbyte_q <= uart_data_io;        // capture as rdn goes high
    end

    assign uart_data_io = drive_q ? wbyte_q : 'z;

    // bit 1 transmitter idle and empty, bit 0 rx byte waiting
    assign status_o = {uart_tbre_i & uart_tsre_i, uart_dataready_i};

    assign resp_o = '{valid: valid_q, rdata: {24'b0, rbyte_q}};  // zero-extended

endmodule

// File: source/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
    input  logic                            clk_50M,
    input  logic                            rst_i,
    // cpu side
    input  bus_pkg::mem_req_t               inst_req_i,
    input  bus_pkg::mem_req_t               data_req_i,
    output bus_pkg::mem_resp_t              inst_resp_o,
    output bus_pkg::mem_resp_t              data_resp_o,
    output logic                            stall_o,
    // ext ram pins
    inout  wire  [31:0]                     ext_ram_data_io,
    output logic [bus_pkg::SRAM_ADDR_W-1:0] ext_ram_addr_o,
    output logic [3:0]                      ext_ram_be_n_o,
    output logic                            ext_ram_ce_n_o,
    output logic                            ext_ram_oe_n_o,
    output logic                            ext_ram_we_n_o,
    // base ram pins
    inout  wire  [31:0]                     base_ram_data_io,
    output logic [bus_pkg::SRAM_ADDR_W-1:0] base_ram_addr_o,
    output logic [3:0]                      base_ram_be_n_o,
    output logic                            base_ram_ce_n_o,
    output logic                            base_ram_oe_n_o,
    output logic                            base_ram_we_n_o,
    // cpld serial chip, own 8-bit bus
    output logic                            uart_rdn_o,
    output logic                            uart_wrn_o,
    input  logic                            uart_dataready_i,
    input  logic                            uart_tbre_i,
    input  logic                            uart_tsre_i,
    inout  wire  [7:0]                      uart_data_io
);

    bus_pkg::mem_req_t  ext_req, base_req, uart_req;
    bus_pkg::mem_resp_t ext_resp, base_resp, uart_resp;
    logic [1:0]         uart_status;

    bus_router router (
        .clk_50M(clk_50M), .rst_i(rst_i),
        .inst_req_i(inst_req_i), .data_req_i(data_req_i),
        .inst_resp_o(inst_resp_o), .data_resp_o(data_resp_o), .stall_o(stall_o),
        .ext_req_o(ext_req), .base_req_o(base_req), .uart_req_o(uart_req),
        .ext_resp_i(ext_resp), .base_resp_i(base_resp), .uart_resp_i(uart_resp),
        .uart_status_i(uart_status)
    );

    sram_controller ext_sram (
        .clk_50M(clk_50M), .rst_i(rst_i), .req_i(ext_req), .resp_o(ext_resp),
        .ram_data_io(ext_ram_data_io), .ram_addr_o(ext_ram_addr_o),
        .ram_be_n_o(ext_ram_be_n_o), .ram_ce_n_o(ext_ram_ce_n_o),
        .ram_oe_n_o(ext_ram_oe_n_o), .ram_we_n_o(ext_ram_we_n_o)
    );

    sram_controller base_sram (
        .clk_50M(clk_50M), .rst_i(rst_i), .req_i(base_req), .resp_o(base_resp),
        .ram_data_io(base_ram_data_io), .ram_addr_o(base_ram_addr_o),
        .ram_be_n_o(base_ram_be_n_o), .ram_ce_n_o(base_ram_ce_n_o),
        .ram_oe_n_o(base_ram_oe_n_o), .ram_we_n_o(base_ram_we_n_o)
    );

    serial_controller serial (
        .clk_50M(clk_50M), .rst_i(rst_i), .req_i(uart_req), .resp_o(uart_resp),
        .status_o(uart_status), .uart_rdn_o(uart_rdn_o), .uart_wrn_o(uart_wrn_o),
        .uart_dataready_i(uart_dataready_i), .uart_tbre_i(uart_tbre_i),
        .uart_tsre_i(uart_tsre_i), .uart_data_io(uart_data_io)
    );

endmodule

// File: source/sram_controller.sv
`timescale 1ns/1ps

module sram_controller (
    input  logic                            clk_50M,
    input  logic                            rst_i,
    input  bus_pkg::mem_req_t               req_i,
    output bus_pkg::mem_resp_t              resp_o,
    inout  wire  [31:0]                     ram_data_io,
    output logic [bus_pkg::SRAM_ADDR_W-1:0] ram_addr_o,
    output logic [3:0]                      ram_be_n_o,
    output logic                            ram_ce_n_o,
    output logic                            ram_oe_n_o,
    output logic                            ram_we_n_o
);

    logic          drive_q;      // we own the data bus
    logic          valid_q;
    bus_pkg::word_t wdata_q;
    bus_pkg::word_t rdata_q;
    logic          req_act;

    assign req_act = req_i.read | req_i.write;

    // strobes: one cycle low, the cycle after the request
    always_ff @(posedge clk_50M) begin
        if (rst_i) begin
            ram_ce_n_o <= 1'b1;
            ram_oe_n_o <= 1'b1;
            ram_we_n_o <= 1'b1;
            drive_q    <= 1'b0;
            valid_q    <= 1'b0;
        end else begin
            ram_ce_n_o <= ~req_act;
            ram_oe_n_o <= ~req_i.read;
            ram_we_n_o <= ~req_i.write;
            drive_q    <= req_i.write;
            valid_q    <= ~ram_ce_n_o;   // access cycle just ended
        end
    end

    always_ff @(posedge clk_50M) begin
        if (req_act) begin
            ram_addr_o <= req_i.addr[bus_pkg::SRAM_ADDR_W-1:0];
            ram_be_n_o <= req_i.read ? 4'b0000 : ~req_i.mask;  // reads take all lanes
            wdata_q    <= req_i.wdata;
        end
        if (!ram_oe_n_o)
            rdata_q <= ram_data_io;     // sample at end of oe_n window
    end

    assign ram_data_io = drive_q ? wdata_q : 'z;

    assign resp_o = '{valid: valid_q, rdata: rdata_q};

endmodule

// File: test/soc_bus_checker.sv
`timescale 1ns/1ps

module soc_bus_checker (
    input logic              clk_50M,
    input logic              rst_i,
    input bus_pkg::mem_req_t inst_req_i,
    input bus_pkg::mem_req_t data_req_i,
    input logic              stall_o,
    input logic              ext_ram_oe_n_o,
    input logic              ext_ram_we_n_o,
    input logic              base_ram_oe_n_o,
    input logic              base_ram_we_n_o,
    input logic              uart_rdn_o,
    input logic              uart_wrn_o
);

    // bus fight on the ram data pins
    ext_rw: assert property (@(posedge clk_50M) disable iff (rst_i)
        !(!ext_ram_we_n_o && !ext_ram_oe_n_o)) else $error("ext ram oe_n and we_n both low");
    base_rw: assert property (@(posedge clk_50M) disable iff (rst_i)
        !(!base_ram_we_n_o && !base_ram_oe_n_o)) else $error("base ram oe_n and we_n both low");
    uart_rw: assert property (@(posedge clk_50M) disable iff (rst_i)
        !(!uart_rdn_o && !uart_wrn_o)) else $error("uart rdn and wrn both low");
    // cpu must hold off while stalled
    no_req_stall: assert property (@(posedge clk_50M) disable iff (rst_i)
        stall_o |-> !(inst_req_i.read || data_req_i.read || data_req_i.write))
        else $error("request issued while stall_o high");

endmodule

bind soc_bus_top soc_bus_checker strobe_chk (
    .clk_50M(clk_50M), .rst_i(rst_i), .inst_req_i(inst_req_i), .data_req_i(data_req_i),
    .stall_o(stall_o), .ext_ram_oe_n_o(ext_ram_oe_n_o), .ext_ram_we_n_o(ext_ram_we_n_o),
    .base_ram_oe_n_o(base_ram_oe_n_o), .base_ram_we_n_o(base_ram_we_n_o),
    .uart_rdn_o(uart_rdn_o), .uart_wrn_o(uart_wrn_o)
);

// File: test/soc_bus_tb.sv
`timescale 1ns/1ps

// async sram, 256 words are enough for the test window
module sram_model (
    input logic       ce_n, oe_n, we_n, clk,
    input logic [3:0] be_n,
    input logic [19:0] addr,
    inout wire [31:0] data
);
    logic [31:0] mem [256];
    assign data = (!ce_n && !oe_n) ? mem[addr[7:0]] : 'z;
    always @(posedge clk) begin
        if (!ce_n && !we_n)
            for (int b = 0; b < 4; b++)
                if (!be_n[b]) mem[addr[7:0]][8*b +: 8] <= data[8*b +: 8];  // lane write
    end
endmodule

module soc_bus_tb;
    typedef struct packed {
        logic [31:0] data;
        logic        chk;  // rdata compared only for reads
        int          lat;
        int          cyc;
    } exp_t;

    logic clk_50M = 0, rst_i;
    bus_pkg::mem_req_t inst_req, data_req;
    bus_pkg::mem_resp_t inst_resp, data_resp;
    logic stall, rdn, wrn, dataready, tbre, tsre;
    wire [31:0] ext_data, base_data;
    wire [7:0] uart_data;
    logic [19:0] ext_addr, base_addr;
    logic [3:0] ext_be_n, base_be_n;
    logic ext_ce_n, ext_oe_n, ext_we_n, base_ce_n, base_oe_n, base_we_n;
    logic [7:0] rx_byte = 8'hA5, tx_byte;   // serial chip model state
    bus_pkg::word_t shadow [bus_pkg::addr_t];
    exp_t inst_q[$], data_q[$];
    int cyc = 0, errors = 0, checks = 0, strobes = 0;

    always #10 clk_50M = ~clk_50M;
    always @(posedge clk_50M) cyc <= cyc + 1;

    soc_bus_top uut (
        .clk_50M(clk_50M), .rst_i(rst_i), .inst_req_i(inst_req), .data_req_i(data_req),
        .inst_resp_o(inst_resp), .data_resp_o(data_resp), .stall_o(stall),
        .ext_ram_data_io(ext_data), .ext_ram_addr_o(ext_addr), .ext_ram_be_n_o(ext_be_n),
        .ext_ram_ce_n_o(ext_ce_n), .ext_ram_oe_n_o(ext_oe_n), .ext_ram_we_n_o(ext_we_n),
        .base_ram_data_io(base_data), .base_ram_addr_o(base_addr),
        .base_ram_be_n_o(base_be_n), .base_ram_ce_n_o(base_ce_n),
        .base_ram_oe_n_o(base_oe_n), .base_ram_we_n_o(base_we_n),
        .uart_rdn_o(rdn), .uart_wrn_o(wrn), .uart_dataready_i(dataready),
        .uart_tbre_i(tbre), .uart_tsre_i(tsre), .uart_data_io(uart_data)
    );

    sram_model ext_model (.ce_n(ext_ce_n), .oe_n(ext_oe_n), .we_n(ext_we_n), .clk(clk_50M),
                          .be_n(ext_be_n), .addr(ext_addr), .data(ext_data));
    sram_model base_model (.ce_n(base_ce_n), .oe_n(base_oe_n), .we_n(base_we_n),
                           .clk(clk_50M), .be_n(base_be_n), .addr(base_addr),
                           .data(base_data));

    assign uart_data = !rdn ? rx_byte : 'z;           // chip drives while rdn low
    always @(posedge wrn) tx_byte <= uart_data;       // latch on wrn rising
    always @(negedge clk_50M)
        if (!rst_i && !(&{ext_ce_n, base_ce_n, rdn, wrn})) strobes <= strobes + 1;

    function automatic bus_pkg::word_t fill_word(input bus_pkg::addr_t a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_1234;   // power-up contents
    endfunction

    function automatic logic in_ram(input bus_pkg::addr_t a);
        return a >= 32'h8000_0000 && a < 32'h8080_0000;  // ext and base back to back
    endfunction

    function automatic bus_pkg::word_t expected_read(input bus_pkg::addr_t a);
        bus_pkg::addr_t w;
        w = {a[31:2], 2'b00};
        if (in_ram(a)) return shadow.exists(w) ? shadow[w] : fill_word(w);
        if (a == bus_pkg::UART_DATA_ADDR) return {24'b0, rx_byte};
        if (a == bus_pkg::UART_STAT_ADDR) return {30'b0, tbre & tsre, dataready};
        return '0;                                     // unmapped
    endfunction

    function automatic bus_pkg::mem_req_t make_req(input logic rd, input logic wr,
                                                   input bus_pkg::addr_t a,
                                                   input bus_pkg::word_t wd,
                                                   input bus_pkg::mask_t m);
        return '{read: rd, write: wr, addr: a, wdata: wd, mask: m};
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_resp(input string name, input exp_t e, input bus_pkg::word_t act);
        if (e.chk) check({name, ".rdata"}, e.data, act);
        check({name, " latency"}, e.lat, cyc - e.cyc);
    endtask

    // compare process, responses sampled mid-cycle
    always @(negedge clk_50M) begin
        if (!rst_i && inst_resp.valid) begin
            if (inst_q.size() == 0) begin
                errors++;
                $display("unexpected instruction response at %0t", $time);
            end else check_resp("inst_resp_o", inst_q.pop_front(), inst_resp.rdata);
        end
        if (!rst_i && data_resp.valid) begin
            if (data_q.size() == 0) begin
                errors++;
                $display("unexpected data response at %0t", $time);
            end else check_resp("data_resp_o", data_q.pop_front(), data_resp.rdata);
        end
    end

    task automatic issue(input logic i_rd, input bus_pkg::addr_t ia,
                         input bus_pkg::mem_req_t dr, input int d_lat);
        exp_t e;
        bus_pkg::word_t m;
        @(posedge clk_50M);
        inst_req <= make_req(i_rd, 1'b0, ia, '0, '0);
        data_req <= dr;
        @(negedge clk_50M);
        if (i_rd) begin
            e = '{data: expected_read(ia), chk: 1'b1, lat: 2, cyc: cyc};
            inst_q.push_back(e);
        end
        if (dr.read || dr.write) begin
            e = '{data: expected_read(dr.addr), chk: dr.read, lat: d_lat, cyc: cyc};
            data_q.push_back(e);
        end
        if (dr.write && in_ram(dr.addr)) begin       // shadow follows the mask rule
            m = {{8{dr.mask[3]}}, {8{dr.mask[2]}}, {8{dr.mask[1]}}, {8{dr.mask[0]}}};
            shadow[{dr.addr[31:2], 2'b00}] = (expected_read(dr.addr) & ~m) | (dr.wdata & m);
        end
        @(posedge clk_50M);
        inst_req <= '0;
        data_req <= '0;
    endtask

    task automatic end_with_failure();
        $display("errors: %0d of %0d checks", errors, checks);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((inst_q.size() != 0 || data_q.size() != 0) && n < 20) begin
            @(posedge clk_50M);
            n++;
        end
        if (inst_q.size() != 0 || data_q.size() != 0) begin
            errors++;
            $display("timeout: a response never arrived");
            end_with_failure();
        end
    endtask

    task automatic expect_stall(input logic [2:0] pattern);
        for (int i = 2; i >= 0; i--) begin
            @(negedge clk_50M);
            check("stall_o", pattern[i], stall);
        end
    endtask

    initial begin
        bus_pkg::addr_t a, b;
        int s;
        void'($urandom(7));
        inst_req = '0;
        data_req = '0;
        rst_i = 1'b1;
        {dataready, tbre, tsre} = 3'b011;
        for (int i = 0; i < 256; i++) begin
            ext_model.mem[i] = fill_word(bus_pkg::EXT_BASE + 4 * i);
            base_model.mem[i] = fill_word(bus_pkg::BASE_BASE + 4 * i);
        end
        repeat (10) @(posedge clk_50M);
        rst_i <= 1'b0;
        @(negedge clk_50M);
        check("ram strobes", 6'h3F, {ext_ce_n, ext_oe_n, ext_we_n, base_ce_n, base_oe_n,
                                     base_we_n});
        check("uart rdn/wrn", 2'b11, {rdn, wrn});
        check("stall/valids", 3'b000, {stall, inst_resp.valid, data_resp.valid});

        repeat (40) begin                             // masked writes, read back
            a = (($urandom % 2) ? bus_pkg::BASE_BASE : bus_pkg::EXT_BASE) + 4 * ($urandom % 256);
            issue(0, '0, make_req(0, 1, a, $urandom, 4'($urandom)), 2);
            wait_idle();
            if ($urandom % 2)                         // read back through either port
                issue(1, a, make_req(0, 0, '0, '0, '0), 2);
            else
                issue(0, '0, make_req(1, 0, a, '0, '0), 2);
            wait_idle();
        end
        a = bus_pkg::EXT_BASE + 4 * ($urandom % 255);   // different rams, a + 4 still in range
        b = bus_pkg::BASE_BASE + 4 * ($urandom % 256);
        issue(1, a, make_req(1, 0, b, '0, '0), 2);
        expect_stall(3'b000);
        wait_idle();
        issue(1, b, make_req(0, 1, a, $urandom, 4'hF), 2);
        expect_stall(3'b000);
        wait_idle();
        issue(1, a, make_req(1, 0, a + 4, '0, '0), 3);  // same ram twice
        expect_stall(3'b110);
        wait_idle();
        issue(1, b, make_req(0, 1, b, $urandom, 4'h6), 3);
        expect_stall(3'b110);
        wait_idle();
        issue(1, b, make_req(1, 0, b, '0, '0), 3);
        expect_stall(3'b110);
        wait_idle();

        issue(0, '0, make_req(0, 1, bus_pkg::UART_DATA_ADDR, 32'h1234_565C, 4'hF), 2);
        wait_idle();
        check("tx_byte", 8'h5C, tx_byte);
        issue(0, '0, make_req(1, 0, bus_pkg::UART_DATA_ADDR, '0, '0), 2);
        wait_idle();
        @(posedge clk_50M) {dataready, tsre} <= 2'b10;  // rx waiting, tx busy
        issue(1, bus_pkg::UART_STAT_ADDR, make_req(0, 0, '0, '0, '0), 2);
        wait_idle();
        @(posedge clk_50M) tsre <= 1'b1;
        issue(0, '0, make_req(1, 0, bus_pkg::UART_STAT_ADDR, '0, '0), 2);
        wait_idle();

        issue(0, '0, make_req(1, 0, 32'h1000_0000, '0, '0), 2);
        wait_idle();
        s = strobes;
        issue(0, '0, make_req(0, 1, 32'h9000_0040, 32'hFFFF_FFFF, 4'hF), 2);
        wait_idle();
        repeat (2) @(posedge clk_50M);
        check("strobe count", s, strobes);            // unmapped write touches no pin

        if (errors == 0) begin
            $display("errors: 0 of %0d checks", checks);
            $display("Done: no errors");
            $finish;
        end else begin
            end_with_failure();
        end
    end
endmodule
